/* design/sudoku_pkg.sv */
package sudoku_pkg;

	// ----------------------------------------------------------------------
	// 640x480 VGA timing, syncs active low.
	// ----------------------------------------------------------------------
	localparam int h_visible    = 640;
	localparam int h_total      = 800;
	localparam int h_sync_start = 656;
	localparam int h_sync_end   = 752;
	localparam int v_visible    = 480;
	localparam int v_total      = 525;
	localparam int v_sync_start = 490;
	localparam int v_sync_end   = 492;

	// ----------------------------------------------------------------------
	// Board and timer layout.
	// ----------------------------------------------------------------------
	localparam int board_dim = 9;
	localparam int num_cells = board_dim * board_dim;
	localparam int cell_size = 52;

	// Same offsets for rows and columns, wider gaps between 3x3 blocks.
	localparam logic [9:0] blk_pos [0:board_dim-1] = '{
		10'd0, 10'd53, 10'd106, 10'd161, 10'd214, 10'd267, 10'd322, 10'd375, 10'd428
	};

	// Indexed by timer digit, digit 3 at the top left.
	localparam int timer_boxes = 4;
	localparam logic [9:0] timer_x [0:timer_boxes-1] = '{10'd560, 10'd500, 10'd560, 10'd500};
	localparam logic [9:0] timer_y [0:timer_boxes-1] = '{10'd260, 10'd260, 10'd200, 10'd200};

	// Seven-segment glyphs, bit 0 is segment a and bit 6 is segment g.
	localparam int max_digit  = 9;
	localparam int seg_thick  = 6;
	localparam int seg_mid_lo = 23;
	localparam int seg_mid_hi = 28;
	localparam logic [6:0] seg_mask [0:max_digit] = '{
		7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07, 7'h7f, 7'h6f
	};

	// Background pattern at half resolution.
	localparam int bg_width  = h_visible / 2;
	localparam int bg_depth  = bg_width * (v_visible / 2);
	localparam int bg_tile   = 8;
	localparam int bg_colors = 5;

	localparam logic [11:0] bg_palette [0:7] = '{
		12'h23a, 12'h019, 12'hd99, 12'hc77, 12'h038, 12'h000, 12'h000, 12'h000
	};
	localparam logic [11:0] col_given  = 12'h000;
	localparam logic [11:0] col_player = 12'hf00;
	localparam logic [11:0] col_timer  = 12'hfff;
	localparam logic [11:0] col_blank  = 12'h000;

	// ----------------------------------------------------------------------
	// Register map and responses.
	// ----------------------------------------------------------------------
	localparam logic [11:0] reg_cell_base = 12'h000;
	localparam logic [11:0] reg_timer     = 12'h144;
	localparam logic [11:0] reg_frame     = 12'h148;
	localparam logic [1:0]  resp_okay     = 2'b00;
	localparam logic [1:0]  resp_slverr   = 2'b10;

	typedef enum logic [1:0] {
		layer_bg,
		layer_given,
		layer_player,
		layer_timer
	} layer_e;

	typedef enum logic {
		wr_idle,
		wr_resp
	} axil_wr_state_e;

	typedef enum logic {
		rd_idle,
		rd_data
	} axil_rd_state_e;

endpackage

/* design/scan_if.sv */
`timescale 1ns/1ps

// Scan position and syncs from the timing generator.
interface scan_if;
	logic [9:0] h_cnt;
	logic [9:0] v_cnt;
	logic       active;
	logic       hsync;
	logic       vsync;

	modport source (
		output h_cnt, v_cnt, active, hsync, vsync
	);

	modport sink (
		input h_cnt, v_cnt, active, hsync, vsync
	);
endinterface

/* design/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing (
	input  logic   clka,
	input  logic   rst_n,
	scan_if.source scan,
	output logic   frame_start
);

	logic [9:0] h_cnt;
	logic [9:0] v_cnt;

	always_ff @(posedge clka or negedge rst_n) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == 10'(sudoku_pkg::h_total - 1)) begin
			h_cnt <= '0;
			if (v_cnt == 10'(sudoku_pkg::v_total - 1)) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 10'd1;
			end
		end else begin
			h_cnt <= h_cnt + 10'd1;
		end
	end

	assign scan.h_cnt  = h_cnt;
	assign scan.v_cnt  = v_cnt;
	assign scan.active = (h_cnt < sudoku_pkg::h_visible) && (v_cnt < sudoku_pkg::v_visible);
	assign scan.hsync  = !((h_cnt >= sudoku_pkg::h_sync_start) &&
		(h_cnt < sudoku_pkg::h_sync_end));
	assign scan.vsync  = !((v_cnt >= sudoku_pkg::v_sync_start) &&
		(v_cnt < sudoku_pkg::v_sync_end));

	// One pulse per frame, at the top left pixel.
	assign frame_start = (h_cnt == 10'd0) && (v_cnt == 10'd0);

	h_cnt_range_a: assert property (
		@(posedge clka) disable iff (!rst_n) h_cnt < sudoku_pkg::h_total
	);

endmodule

/* design/board_regs_axil.sv */
`timescale 1ns/1ps

module board_regs_axil (
	input  logic        clka,
	input  logic        rst_n,
	input  logic [11:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [11:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	input  logic        frame_start,
	output logic [sudoku_pkg::num_cells*4-1:0] board,
	output logic [sudoku_pkg::num_cells-1:0]   board_given,
	output logic [15:0] timer_digits
);

	sudoku_pkg::axil_wr_state_e wr_state;
	sudoku_pkg::axil_rd_state_e rd_state;

	logic [31:0] frame_cnt;
	logic [11:0] wr_off;
	logic [11:0] rd_off;
	logic [6:0]  wr_cell;
	logic [6:0]  rd_cell;
	logic        wr_is_cell;
	logic        wr_is_timer;
	logic        wr_legal;
	logic [31:0] rd_word;
	logic        rd_legal;

	// ----------------------------------------------------------------------
	// Address decode.
	// ----------------------------------------------------------------------
	assign wr_off      = awaddr - sudoku_pkg::reg_cell_base;
	assign rd_off      = araddr - sudoku_pkg::reg_cell_base;
	assign wr_cell     = wr_off[8:2];
	assign rd_cell     = rd_off[8:2];
	assign wr_is_cell  = wr_off < 12'(4 * sudoku_pkg::num_cells);
	assign wr_is_timer = awaddr[11:2] == sudoku_pkg::reg_timer[11:2];

	// Digits above nine are refused, as are frame and unmapped writes.
	assign wr_legal = (wr_is_cell && (wdata[3:0] <= 4'(sudoku_pkg::max_digit))) ||
		wr_is_timer;

	always_comb begin
		rd_word  = '0;
		rd_legal = 1'b1;
		if (rd_off < 12'(4 * sudoku_pkg::num_cells)) begin
			rd_word = {27'd0, board_given[rd_cell], board[rd_cell*4 +: 4]};
		end else if (araddr[11:2] == sudoku_pkg::reg_timer[11:2]) begin
			rd_word = {16'd0, timer_digits};
		end else if (araddr[11:2] == sudoku_pkg::reg_frame[11:2]) begin
			rd_word = frame_cnt;
		end else begin
			rd_legal = 1'b0;
		end
	end

	// ----------------------------------------------------------------------
	// Write channel.
	// ----------------------------------------------------------------------
	assign awready = (wr_state == sudoku_pkg::wr_idle) && awvalid && wvalid;
	assign wready  = awready;
	assign bvalid  = wr_state == sudoku_pkg::wr_resp;

	always_ff @(posedge clka or negedge rst_n) begin
		if (!rst_n) begin
			wr_state     <= sudoku_pkg::wr_idle;
			bresp        <= sudoku_pkg::resp_okay;
			board        <= '0;
			board_given  <= '0;
			timer_digits <= '0;
		end else begin
			case (wr_state)
				sudoku_pkg::wr_idle: begin
					if (awready) begin
						wr_state <= sudoku_pkg::wr_resp;
						bresp    <= wr_legal ? sudoku_pkg::resp_okay : sudoku_pkg::resp_slverr;
						if (wr_legal && wr_is_cell && wstrb[0]) begin
							board[wr_cell*4 +: 4] <= wdata[3:0];
							board_given[wr_cell]  <= wdata[4];
						end
						if (wr_legal && wr_is_timer) begin
							if (wstrb[0]) begin
								timer_digits[7:0] <= wdata[7:0];
							end
							if (wstrb[1]) begin
								timer_digits[15:8] <= wdata[15:8];
							end
						end
					end
				end
				sudoku_pkg::wr_resp: begin
					if (bready) begin
						wr_state <= sudoku_pkg::wr_idle;
					end
				end
				default: wr_state <= sudoku_pkg::wr_idle;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// Read channel.
	// ----------------------------------------------------------------------
	assign arready = (rd_state == sudoku_pkg::rd_idle) && arvalid;
	assign rvalid  = rd_state == sudoku_pkg::rd_data;

	always_ff @(posedge clka or negedge rst_n) begin
		if (!rst_n) begin
			rd_state <= sudoku_pkg::rd_idle;
			rdata    <= '0;
			rresp    <= sudoku_pkg::resp_okay;
		end else begin
			case (rd_state)
				sudoku_pkg::rd_idle: begin
					if (arready) begin
						rd_state <= sudoku_pkg::rd_data;
						rdata    <= rd_word;
						rresp    <= rd_legal ? sudoku_pkg::resp_okay : sudoku_pkg::resp_slverr;
					end
				end
				sudoku_pkg::rd_data: begin
					if (rready) begin
						rd_state <= sudoku_pkg::rd_idle;
					end
				end
				default: rd_state <= sudoku_pkg::rd_idle;
			endcase
		end
	end

	always_ff @(posedge clka or negedge rst_n) begin
		if (!rst_n) begin
			frame_cnt <= '0;
		end else if (frame_start) begin
			frame_cnt <= frame_cnt + 32'd1;
		end
	end

	// Responses hold steady while the master stalls.
	bvalid_hold_a: assert property (
		@(posedge clka) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp)
	);

	rvalid_hold_a: assert property (
		@(posedge clka) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
	);

endmodule

/* design/game_pixel_gen.sv */
`timescale 1ns/1ps

module game_pixel_gen (
	input  logic                                clka,
	input  logic                                rst_n,
	scan_if.sink                                scan,
	input  logic [sudoku_pkg::num_cells*4-1:0]  board,
	input  logic [sudoku_pkg::num_cells-1:0]    board_given,
	input  logic [15:0]                         timer_digits,
	output logic [3:0]                          glyph_digit,
	output logic [5:0]                          glyph_x,
	output logic [5:0]                          glyph_y,
	output logic [16:0]                         bg_addr,
	output sudoku_pkg::layer_e                  layer
);

	// Returns a hit flag and the slot index, gaps give no hit.
	function automatic logic [4:0] find_slot(input logic [9:0] pos);
		logic [4:0] slot;
		slot = '0;
		for (int i = 0; i < sudoku_pkg::board_dim; i++) begin
			if ((pos >= sudoku_pkg::blk_pos[i]) &&
				(pos < sudoku_pkg::blk_pos[i] + sudoku_pkg::cell_size)) begin
				slot = {1'b1, 4'(i)};
			end
		end
		return slot;
	endfunction

	logic [4:0]         row_slot;
	logic [4:0]         col_slot;
	logic [6:0]         cell_idx;
	logic [3:0]         cell_digit;
	logic               cell_on;
	logic               timer_hit;
	logic [1:0]         timer_sel;
	logic [9:0]         box_x;
	logic [9:0]         box_y;
	sudoku_pkg::layer_e layer_next;

	assign row_slot   = find_slot(scan.v_cnt);
	assign col_slot   = find_slot(scan.h_cnt);
	assign cell_idx   = 7'(row_slot[3:0] * sudoku_pkg::board_dim + col_slot[3:0]);
	assign cell_digit = board[cell_idx*4 +: 4];
	assign cell_on    = row_slot[4] && col_slot[4] && (cell_digit != 4'd0);

	always_comb begin
		timer_hit = 1'b0;
		timer_sel = '0;
		for (int i = 0; i < sudoku_pkg::timer_boxes; i++) begin
			if ((scan.h_cnt >= sudoku_pkg::timer_x[i]) &&
				(scan.h_cnt < sudoku_pkg::timer_x[i] + sudoku_pkg::cell_size) &&
				(scan.v_cnt >= sudoku_pkg::timer_y[i]) &&
				(scan.v_cnt < sudoku_pkg::timer_y[i] + sudoku_pkg::cell_size)) begin
				timer_hit = 1'b1;
				timer_sel = 2'(i);
			end
		end
	end

	// Offset inside the glyph box and the digit to draw there.
	always_comb begin
		if (cell_on) begin
			box_x       = scan.h_cnt - sudoku_pkg::blk_pos[col_slot[3:0]];
			box_y       = scan.v_cnt - sudoku_pkg::blk_pos[row_slot[3:0]];
			glyph_digit = cell_digit;
		end else if (timer_hit) begin
			box_x       = scan.h_cnt - sudoku_pkg::timer_x[timer_sel];
			box_y       = scan.v_cnt - sudoku_pkg::timer_y[timer_sel];
			glyph_digit = timer_digits[timer_sel*4 +: 4];
		end else begin
			box_x       = '0;
			box_y       = '0;
			glyph_digit = '0;
		end
	end

	assign glyph_x = box_x[5:0];
	assign glyph_y = box_y[5:0];
	assign bg_addr = 17'(scan.h_cnt[9:1]) + 17'(scan.v_cnt[9:1]) * 17'(sudoku_pkg::bg_width);

	always_comb begin
		if (!scan.active) begin
			layer_next = sudoku_pkg::layer_bg;
		end else if (cell_on) begin
			layer_next = board_given[cell_idx] ? sudoku_pkg::layer_given : sudoku_pkg::layer_player;
		end else if (timer_hit) begin
			layer_next = sudoku_pkg::layer_timer;
		end else begin
			layer_next = sudoku_pkg::layer_bg;
		end
	end

	always_ff @(posedge clka or negedge rst_n) begin
		if (!rst_n) begin
			layer <= sudoku_pkg::layer_bg;
		end else begin
			layer <= layer_next;
		end
	end

endmodule

/* design/digit_glyph.sv */
`timescale 1ns/1ps

module digit_glyph (
	input  logic       clka,
	input  logic [3:0] glyph_digit,
	input  logic [5:0] glyph_x,
	input  logic [5:0] glyph_y,
	output logic       pixel_on
);

	logic [6:0] mask;
	logic [6:0] seg_hit;
	logic       band_x;
	logic       left;
	logic       right;
	logic       upper;

	assign mask = (glyph_digit <= 4'(sudoku_pkg::max_digit)) ?
		sudoku_pkg::seg_mask[glyph_digit] : 7'd0;

	// Horizontal bands leave the corners to the vertical sides.
	assign band_x = (glyph_x >= sudoku_pkg::seg_thick) &&
		(glyph_x < sudoku_pkg::cell_size - sudoku_pkg::seg_thick);
	assign left   = glyph_x < sudoku_pkg::seg_thick;
	assign right  = glyph_x >= sudoku_pkg::cell_size - sudoku_pkg::seg_thick;
	assign upper  = glyph_y < sudoku_pkg::cell_size / 2;

	assign seg_hit[0] = band_x && (glyph_y < sudoku_pkg::seg_thick);
	assign seg_hit[1] = right && upper;
	assign seg_hit[2] = right && !upper;
	assign seg_hit[3] = band_x && (glyph_y >= sudoku_pkg::cell_size - sudoku_pkg::seg_thick);
	assign seg_hit[4] = left && !upper;
	assign seg_hit[5] = left && upper;
	assign seg_hit[6] = band_x && (glyph_y >= sudoku_pkg::seg_mid_lo) &&
		(glyph_y <= sudoku_pkg::seg_mid_hi);

	always_ff @(posedge clka) begin
		pixel_on <= |(mask & seg_hit);
	end

endmodule

/* design/background_mem.sv */
`timescale 1ns/1ps

module background_mem (
	input  logic        clka,
	input  logic [16:0] addr,
	output logic [2:0]  index
);

	logic [2:0] rom [0:sudoku_pkg::bg_depth-1];

	// Diagonal stripes of 8x8 tiles cycling through the palette.
	initial begin
		for (int a = 0; a < sudoku_pkg::bg_depth; a++) begin
			rom[a] = 3'(((a % sudoku_pkg::bg_width) / sudoku_pkg::bg_tile +
				(a / sudoku_pkg::bg_width) / sudoku_pkg::bg_tile) % sudoku_pkg::bg_colors);
		end
	end

	// Blanking lines address past the end.
	always_ff @(posedge clka) begin
		if (addr < sudoku_pkg::bg_depth) begin
			index <= rom[addr];
		end else begin
			index <= '0;
		end
	end

endmodule

/* design/pixel_compose.sv */
`timescale 1ns/1ps

module pixel_compose (
	input  logic               clka,
	input  logic               rst_n,
	scan_if.sink               scan,
	input  sudoku_pkg::layer_e layer,
	input  logic               pixel_on,
	input  logic [2:0]         bg_index,
	output logic [11:0]        rgb,
	output logic               hsync,
	output logic               vsync
);

	logic        hsync_d;
	logic        vsync_d;
	logic        active_d;
	logic [11:0] fg_col;
	logic [11:0] pix_col;

	always_comb begin
		case (layer)
			sudoku_pkg::layer_given:  fg_col = sudoku_pkg::col_given;
			sudoku_pkg::layer_player: fg_col = sudoku_pkg::col_player;
			default:                  fg_col = sudoku_pkg::col_timer;
		endcase
	end

	assign pix_col = ((layer != sudoku_pkg::layer_bg) && pixel_on) ? fg_col :
		sudoku_pkg::bg_palette[bg_index];

	// First stage lines the syncs up with the registered layer data.
	always_ff @(posedge clka or negedge rst_n) begin
		if (!rst_n) begin
			hsync_d  <= 1'b1;
			vsync_d  <= 1'b1;
			active_d <= 1'b0;
			rgb      <= sudoku_pkg::col_blank;
			hsync    <= 1'b1;
			vsync    <= 1'b1;
		end else begin
			hsync_d  <= scan.hsync;
			vsync_d  <= scan.vsync;
			active_d <= scan.active;
			rgb      <= active_d ? pix_col : sudoku_pkg::col_blank;
			hsync    <= hsync_d;
			vsync    <= vsync_d;
		end
	end

endmodule

/* design/sudoku_display_top.sv */
`timescale 1ns/1ps

module sudoku_display_top (
	input  logic        clka,
	input  logic        rst_n,
	input  logic [11:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [11:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	output logic [11:0] rgb,
	output logic        hsync,
	output logic        vsync
);

	logic                                frame_start;
	logic [sudoku_pkg::num_cells*4-1:0]  board;
	logic [sudoku_pkg::num_cells-1:0]    board_given;
	logic [15:0]                         timer_digits;
	logic [3:0]                          glyph_digit;
	logic [5:0]                          glyph_x;
	logic [5:0]                          glyph_y;
	logic [16:0]                         bg_addr;
	sudoku_pkg::layer_e                  layer;
	logic                                pixel_on;
	logic [2:0]                          bg_index;

	scan_if scan ();

	vga_timing vga_timing_u (
		.clka        (clka),
		.rst_n       (rst_n),
		.scan        (scan.source),
		.frame_start (frame_start)
	);

	board_regs_axil board_regs_axil_u (
		.clka         (clka),
		.rst_n        (rst_n),
		.awaddr       (awaddr),
		.awvalid      (awvalid),
		.awready      (awready),
		.wdata        (wdata),
		.wstrb        (wstrb),
		.wvalid       (wvalid),
		.wready       (wready),
		.bresp        (bresp),
		.bvalid       (bvalid),
		.bready       (bready),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rresp        (rresp),
		.rvalid       (rvalid),
		.rready       (rready),
		.frame_start  (frame_start),
		.board        (board),
		.board_given  (board_given),
		.timer_digits (timer_digits)
	);

	game_pixel_gen game_pixel_gen_u (
		.clka         (clka),
		.rst_n        (rst_n),
		.scan         (scan.sink),
		.board        (board),
		.board_given  (board_given),
		.timer_digits (timer_digits),
		.glyph_digit  (glyph_digit),
		.glyph_x      (glyph_x),
		.glyph_y      (glyph_y),
		.bg_addr      (bg_addr),
		.layer        (layer)
	);

	digit_glyph digit_glyph_u (
		.clka        (clka),
		.glyph_digit (glyph_digit),
		.glyph_x     (glyph_x),
		.glyph_y     (glyph_y),
		.pixel_on    (pixel_on)
	);

	background_mem background_mem_u (
		.clka  (clka),
		.addr  (bg_addr),
		.index (bg_index)
	);

	pixel_compose pixel_compose_u (
		.clka     (clka),
		.rst_n    (rst_n),
		.scan     (scan.sink),
		.layer    (layer),
		.pixel_on (pixel_on),
		.bg_index (bg_index),
		.rgb      (rgb),
		.hsync    (hsync),
		.vsync    (vsync)
	);

endmodule

/* testbench/tb_sudoku_display.sv */
`timescale 1ns/1ps

module tb_sudoku_display;

	localparam int frame_cycles = sudoku_pkg::h_total * sudoku_pkg::v_total;
	// The first three tests finish inside frame zero and the last three wait one frame at most.
	localparam int timeout_cycles = 4 * frame_cycles + 20000;

	logic        clka;
	logic        rst_n;
	logic [11:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [11:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic [11:0] rgb;
	logic        hsync;
	logic        vsync;

	// Board contents as written over the bus.
	logic [3:0]  model_digit [0:80];
	logic        model_given [0:80];
	logic [15:0] model_timer;
	logic [31:0] rng_state;

	int   scan_h;
	int   scan_v;
	int   mid_h;
	int   mid_v;
	int   out_h;
	int   out_v;
	logic mid_valid;
	logic out_valid;
	int   errors;
	int   test_errors;
	int   checks;
	int   tests_run;
	int   cycle_count;

	sudoku_display_top sudoku_display_top_i (
		.clka    (clka),
		.rst_n   (rst_n),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.rgb     (rgb),
		.hsync   (hsync),
		.vsync   (vsync)
	);

	always #2 clka = ~clka;

	// ----------------------------------------------------------------------
	// Scan position model that names the pixel now on rgb.
	// ----------------------------------------------------------------------
	always @(posedge clka or negedge rst_n) begin
		if (!rst_n) begin
			scan_h    <= 0;
			scan_v    <= 0;
			mid_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			mid_h     <= scan_h;
			mid_v     <= scan_v;
			mid_valid <= 1'b1;
			out_h     <= mid_h;
			out_v     <= mid_v;
			out_valid <= mid_valid;
			if (scan_h == sudoku_pkg::h_total - 1) begin
				scan_h <= 0;
				scan_v <= (scan_v == sudoku_pkg::v_total - 1) ? 0 : scan_v + 1;
			end else begin
				scan_h <= scan_h + 1;
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clka);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("TESTS FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int rand_below(input int n);
		rng_state = xorshift32(rng_state);
		return int'(rng_state % 32'(n));
	endfunction

	function automatic int blk(input int i);
		return int'(sudoku_pkg::blk_pos[i]);
	endfunction

	// Column inside the box that is lit for any digit.
	function automatic int lit_column(input int digit);
		return (digit == 2) ? 2 : 48;
	endfunction

	function automatic logic segment_lit(input int digit, input int x, input int y);
		logic [6:0] seg;
		logic       band;
		logic       upper;
		int         t;
		t     = sudoku_pkg::seg_thick;
		band  = (x >= t) && (x < sudoku_pkg::cell_size - t);
		upper = y < sudoku_pkg::cell_size / 2;
		seg[0] = band && (y < t);
		seg[1] = (x >= sudoku_pkg::cell_size - t) && upper;
		seg[2] = (x >= sudoku_pkg::cell_size - t) && !upper;
		seg[3] = band && (y >= sudoku_pkg::cell_size - t);
		seg[4] = (x < t) && !upper;
		seg[5] = (x < t) && upper;
		seg[6] = band && (y >= 23) && (y <= 28);
		if (digit > 9) begin
			return 1'b0;
		end
		return |(sudoku_pkg::seg_mask[digit] & seg);
	endfunction

	function automatic logic [11:0] expected_rgb(input int h, input int v);
		int          row;
		int          col;
		int          idx;
		int          bx;
		int          by;
		logic [11:0] bg;
		if (h >= sudoku_pkg::h_visible || v >= sudoku_pkg::v_visible) begin
			return 12'h000;
		end
		bg  = sudoku_pkg::bg_palette[((h / 2) / 8 + (v / 2) / 8) % 5];
		row = -1;
		col = -1;
		for (int i = 0; i < 9; i++) begin
			if (v >= blk(i) && v < blk(i) + sudoku_pkg::cell_size) begin
				row = i;
			end
			if (h >= blk(i) && h < blk(i) + sudoku_pkg::cell_size) begin
				col = i;
			end
		end
		if (row >= 0 && col >= 0 && model_digit[row * 9 + col] != 4'd0) begin
			idx = row * 9 + col;
			if (segment_lit(int'(model_digit[idx]), h - blk(col), v - blk(row))) begin
				return model_given[idx] ? 12'h000 : 12'hf00;
			end
			return bg;
		end
		// Timer digit 3 sits top left, digit 0 bottom right.
		for (int t = 0; t < 4; t++) begin
			bx = (t % 2 == 1) ? 500 : 560;
			by = (t >= 2) ? 200 : 260;
			if (h >= bx && h < bx + 52 && v >= by && v < by + 52) begin
				return segment_lit(int'(model_timer[t * 4 +: 4]), h - bx, v - by) ? 12'hfff : bg;
			end
		end
		return bg;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			$display("FAILED at %0d ns: %s is %0h, expected %0h", $time, what, got, want);
			errors++;
			test_errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		$display("test %s done, %0d mismatches", name, test_errors);
		test_errors = 0;
	endtask

	task automatic wait_pixel(input int h, input int v);
		do begin
			@(negedge clka);
		end while (!(out_valid && out_h == h && out_v == v));
	endtask

	task automatic check_pixel(input int h, input int v);
		wait_pixel(h, v);
		check_value($sformatf("rgb at (%0d,%0d)", h, v), rgb, expected_rgb(h, v));
	endtask

	// ----------------------------------------------------------------------
	// AXI4-Lite master.
	// ----------------------------------------------------------------------
	task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [1:0] want_resp, input int hold_cycles);
		@(negedge clka);
		awaddr  = addr;
		awvalid = 1'b1;
		wdata   = data;
		wstrb   = strb;
		wvalid  = 1'b1;
		// Ready is seen just before the edge that takes the request.
		do begin
			@(posedge clka);
		end while (!awready);
		check_value("wready with awready", wready, 1'b1);
		@(negedge clka);
		check_value("awready after accept", awready, 1'b0);
		check_value("wready after accept", wready, 1'b0);
		check_value("bvalid after accept", bvalid, 1'b1);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		check_value("bresp", bresp, want_resp);
		repeat (hold_cycles) begin
			@(negedge clka);
			check_value("bvalid while bready low", bvalid, 1'b1);
		end
		bready = 1'b1;
		@(negedge clka);
		bready = 1'b0;
		check_value("bvalid after bready", bvalid, 1'b0);
	endtask

	task automatic axil_read(input logic [11:0] addr, input logic [1:0] want_resp,
		output logic [31:0] data);
		@(negedge clka);
		araddr  = addr;
		arvalid = 1'b1;
		do begin
			@(posedge clka);
		end while (!arready);
		@(negedge clka);
		check_value("arready after accept", arready, 1'b0);
		check_value("rvalid after accept", rvalid, 1'b1);
		arvalid = 1'b0;
		check_value("rresp", rresp, want_resp);
		data   = rdata;
		rready = 1'b1;
		@(negedge clka);
		rready = 1'b0;
		check_value("rvalid after rready", rvalid, 1'b0);
	endtask

	task automatic write_cell(input int idx, input int digit, input logic given, input int hold);
		axil_write(12'(4 * idx), {27'd0, given, 4'(digit)}, 4'hf, sudoku_pkg::resp_okay, hold);
		model_digit[idx] = 4'(digit);
		model_given[idx] = given;
	endtask

	// ----------------------------------------------------------------------
	// Tests.
	// ----------------------------------------------------------------------
	task automatic test_reset_scan();
		check_value("hsync after reset", hsync, 1'b1);
		check_value("vsync after reset", vsync, 1'b1);
		check_value("rgb after reset", rgb, 12'h000);
		for (int h = 0; h < sudoku_pkg::h_visible; h++) begin
			check_pixel(h, 0);
		end
		for (int v = 0; v < 4; v++) begin
			wait_pixel(655, v);
			check_value("hsync before 656", hsync, 1'b1);
			check_value("vsync on line", vsync, 1'b1);
			wait_pixel(656, v);
			check_value("hsync at 656", hsync, 1'b0);
		end
		end_test("reset_scan");
	endtask

	task automatic test_registers();
		int          idx;
		int          digit;
		logic        given;
		logic [31:0] rd;
		for (int n = 0; n < 8; n++) begin
			idx   = rand_below(81);
			digit = 1 + rand_below(9);
			given = rand_below(2) == 1;
			write_cell(idx, digit, given, 0);
			axil_read(12'(4 * idx), sudoku_pkg::resp_okay, rd);
			check_value("cell read back", rd, {27'd0, given, 4'(digit)});
		end
		axil_write(12'(4 * idx), 32'h0000_001c, 4'hf, sudoku_pkg::resp_slverr, 0);
		axil_write(12'h148, 32'h0000_1234, 4'hf, sudoku_pkg::resp_slverr, 0);
		axil_read(12'(4 * idx), sudoku_pkg::resp_okay, rd);
		check_value("cell after rejected write", rd, {27'd0, model_given[idx], model_digit[idx]});
		axil_read(12'h144, sudoku_pkg::resp_okay, rd);
		check_value("timer after rejected write", rd, {16'd0, model_timer});
		axil_read(12'h200, sudoku_pkg::resp_slverr, rd);
		end_test("registers");
	endtask

	task automatic test_given_digit();
		int idx;
		int digit;
		int row;
		int col;
		idx   = rand_below(81);
		digit = 1 + rand_below(9);
		row   = idx / 9;
		col   = idx % 9;
		write_cell(idx, digit, 1'b1, 0);
		// Gap pixel first, then points in scan order.
		check_pixel((col < 8) ? blk(col) + 52 : blk(col) - 1, blk(row) + 10);
		check_pixel(blk(col) + 26, blk(row) + 14);
		check_pixel(blk(col) + lit_column(digit), blk(row) + 40);
		end_test("given_digit");
	endtask

	task automatic test_player_digit();
		int idx;
		int digit;
		int row;
		int col_a;
		int col_b;
		int first;
		int second;
		idx   = rand_below(81);
		digit = 1 + rand_below(9);
		row   = idx / 9;
		col_a = idx % 9;
		col_b = (col_a + 1 + rand_below(8)) % 9;
		write_cell(idx, digit, 1'b0, 0);
		write_cell(row * 9 + col_b, 0, 1'b0, 0);
		first  = (col_a < col_b) ? col_a : col_b;
		second = (col_a < col_b) ? col_b : col_a;
		check_pixel(blk(first) + 26, blk(row) + 14);
		check_pixel(blk(second) + 26, blk(row) + 14);
		check_pixel(blk(first) + lit_column(digit), blk(row) + 40);
		check_pixel(blk(second) + lit_column(digit), blk(row) + 40);
		end_test("player_digit");
	endtask

	task automatic test_timer_digits();
		logic [15:0] value;
		logic [31:0] rd;
		int          by;
		for (int t = 0; t < 4; t++) begin
			value[t * 4 +: 4] = 4'(rand_below(10));
		end
		axil_write(12'h144, {16'd0, value}, 4'b0011, sudoku_pkg::resp_okay, 0);
		model_timer = value;
		axil_read(12'h144, sudoku_pkg::resp_okay, rd);
		check_value("timer read back", rd, {16'd0, value});
		for (int r = 1; r >= 0; r--) begin
			by = (r == 1) ? 200 : 260;
			check_pixel(526, by + 14);
			check_pixel(586, by + 14);
			check_pixel(500 + lit_column(int'(value[(2 * r + 1) * 4 +: 4])), by + 40);
			check_pixel(560 + lit_column(int'(value[(2 * r) * 4 +: 4])), by + 40);
			check_pixel(480, by + 45);
			check_pixel(620, by + 45);
		end
		end_test("timer_digits");
	endtask

	task automatic test_backpressure_frame();
		int          idx;
		int          digit;
		int          h;
		int          v;
		logic [31:0] rd;
		logic [31:0] frame_a;
		logic [31:0] frame_b;
		idx   = rand_below(81);
		digit = 1 + rand_below(9);
		write_cell(idx, digit, 1'b0, 5);
		axil_read(12'(4 * idx), sudoku_pkg::resp_okay, rd);
		check_value("cell after held response", rd, {27'd0, 1'b0, 4'(digit)});
		axil_read(12'h148, sudoku_pkg::resp_okay, frame_a);
		h = out_h;
		v = out_v;
		wait_pixel(h, v);
		axil_read(12'h148, sudoku_pkg::resp_okay, frame_b);
		check_value("frame count step", frame_b, frame_a + 32'd1);
		end_test("backpressure_frame");
	endtask

	initial begin
		clka        = 1'b0;
		rst_n       = 1'b0;
		awaddr      = '0;
		awvalid     = 1'b0;
		wdata       = '0;
		wstrb       = '0;
		wvalid      = 1'b0;
		bready      = 1'b0;
		araddr      = '0;
		arvalid     = 1'b0;
		rready      = 1'b0;
		rng_state   = 32'h2ec211a8;
		model_timer = '0;
		errors      = 0;
		test_errors = 0;
		checks      = 0;
		tests_run   = 0;
		for (int i = 0; i < 81; i++) begin
			model_digit[i] = 4'd0;
			model_given[i] = 1'b0;
		end
		repeat (4) @(negedge clka);
		rst_n = 1'b1;
		test_reset_scan();
		test_registers();
		test_given_digit();
		test_player_digit();
		test_timer_digits();
		test_backpressure_frame();
		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
design/sudoku_pkg.sv
design/scan_if.sv
design/vga_timing.sv
design/board_regs_axil.sv
design/game_pixel_gen.sv
design/digit_glyph.sv
design/background_mem.sv
design/pixel_compose.sv
design/sudoku_display_top.sv
testbench/tb_sudoku_display.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from its output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module tb_sudoku_display -o tb_sudoku_display
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_sudoku_display)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
	exit 0
fi
echo "Simulation did not report success"
exit 1
